// ==== adc_uart_streamer.f ====
design/adc_uart_pkg.sv
design/ltc2308_reader.sv
design/sample_text_framer.sv
design/uart_tx_serializer.sv
design/adc_uart_streamer.sv
verification/adc_uart_streamer_properties.sv
verification/adc_uart_streamer_tb.sv

// ==== design/adc_uart_pkg.sv ====
// ADC to UART shared definitions
package adc_uart_pkg;

	// ==================================================
	// Timing constants
	// ==================================================

	// Clocks between successive CONVST rising edges
	localparam int sample_period_cycles = 2000;
	// CONVST high time covering the conversion
	localparam int conv_wait_cycles = 80;
	// Clocks per SCK half period
	localparam int sck_half_cycles = 2;
	// Clocks per UART bit
	localparam int baud_cycles = 8;

	// ==================================================
	// Widths and sizes
	// ==================================================

	localparam int sample_bits = 12;
	// SD, OS, S1, S0, UNI, SLP
	localparam int config_bits = 6;
	// "chN=0x" plus four hex digits plus CR LF
	localparam int message_bytes = 12;

	typedef logic [2:0] channel_t;
	typedef logic [sample_bits-1:0] sample_t;
	typedef logic [7:0] char_t;

	// One result tagged with the channel it was converted on
	typedef struct packed {
		channel_t channel;
		sample_t value;
	} adc_sample_t;

	// Reader FSM
	typedef enum logic [1:0] {
		reader_idle,
		reader_convert,
		reader_shift
	} reader_state_t;

	// Framer FSM
	typedef enum logic [1:0] {
		framer_idle,
		framer_send,
		framer_wait_done
	} framer_state_t;

endpackage

// ==== design/adc_uart_streamer.sv ====
// ADC to serial streamer top
`timescale 1ns/1ps

module adc_uart_streamer (
	input  logic                    pll0_clock0,
	input  logic                    master_reset_n,
	input  adc_uart_pkg::channel_t  channel,
	input  logic                    sdo,
	output logic                    convst,
	output logic                    sck,
	output logic                    sdi,
	output logic                    tx
);
	import adc_uart_pkg::*;

	// Reader to framer
	adc_sample_t sample;
	logic sample_strobe;
	// Framer to serializer
	char_t tx_byte;
	logic byte_strobe;
	logic byte_done;

	// ==================================================
	// ADC readout
	// ==================================================

	ltc2308_reader reader_0 (
		.pll0_clock0(pll0_clock0),
		.master_reset_n(master_reset_n),
		.channel(channel),
		.sdo(sdo),
		.convst(convst),
		.sck(sck),
		.sdi(sdi),
		.sample(sample),
		.sample_strobe(sample_strobe)
	);

	// Text line per sample
	sample_text_framer framer_0 (
		.pll0_clock0(pll0_clock0),
		.master_reset_n(master_reset_n),
		.sample(sample),
		.sample_strobe(sample_strobe),
		.byte_done(byte_done),
		.tx_byte(tx_byte),
		.byte_strobe(byte_strobe)
	);

	// Serial output
	uart_tx_serializer serializer_0 (
		.pll0_clock0(pll0_clock0),
		.master_reset_n(master_reset_n),
		.tx_byte(tx_byte),
		.byte_strobe(byte_strobe),
		.tx(tx),
		.byte_done(byte_done)
	);

endmodule

// ==== design/ltc2308_reader.sv ====
// LTC2308 conversion and readout
`timescale 1ns/1ps

module ltc2308_reader (
	input  logic                       pll0_clock0,
	input  logic                       master_reset_n,
	input  adc_uart_pkg::channel_t     channel,
	input  logic                       sdo,
	output logic                       convst,
	output logic                       sck,
	output logic                       sdi,
	output adc_uart_pkg::adc_sample_t  sample,
	output logic                       sample_strobe
);
	import adc_uart_pkg::*;

	reader_state_t state;
	logic [$clog2(sample_period_cycles)-1:0] period_count;
	logic [$clog2(conv_wait_cycles)-1:0] wait_count;
	logic [$clog2(sck_half_cycles)-1:0] half_count;
	logic [$clog2(sample_bits)-1:0] bit_count;
	// Config word still to go out on SDI, MSB first
	logic [config_bits-1:0] config_shift;
	// Channel sent with the current frame
	channel_t config_channel;
	// Channel the current conversion really runs on
	channel_t converted_channel;
	sample_t result_shift;
	logic launch;
	logic half_end;
	logic rise_tick;
	logic result_ready;

	// ==================================================
	// Conversion period timer
	// ==================================================

	// Free running, so CONVST edges stay exactly one period apart
	assign launch = (period_count == sample_period_cycles - 1);

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			period_count <= '0;
		end else if (launch) begin
			period_count <= '0;
		end else begin
			period_count <= period_count + 1'b1;
		end
	end

	// SCK divider decodes
	assign half_end = (half_count == sck_half_cycles - 1);
	assign rise_tick = (state == reader_shift) && !sck && half_end;
	// First high cycle of the last SCK pulse, all 12 bits are in
	assign result_ready = (state == reader_shift) && sck && (half_count == 0) &&
		(bit_count == sample_bits - 1);

	// ==================================================
	// Conversion and SPI FSM
	// ==================================================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			state <= reader_idle;
			convst <= 1'b0;
			sck <= 1'b0;
			sdi <= 1'b0;
			wait_count <= '0;
			half_count <= '0;
			bit_count <= '0;
			config_shift <= '0;
			config_channel <= '0;
			converted_channel <= '0;
			sample_strobe <= 1'b0;
		end else begin
			sample_strobe <= result_ready;
			case (state)
				reader_idle: begin
					if (launch) begin
						convst <= 1'b1;
						wait_count <= '0;
						// Word applies to the next conversion
						config_channel <= channel;
						converted_channel <= config_channel;
						// Single ended, odd, select 1, select 0, unipolar, awake
						config_shift <= {1'b1, channel[0], channel[2], channel[1], 1'b1, 1'b0};
						state <= reader_convert;
					end
				end
				reader_convert: begin
					if (wait_count == conv_wait_cycles - 1) begin
						convst <= 1'b0;
						// First config bit ahead of the first SCK rise
						sdi <= config_shift[config_bits-1];
						config_shift <= config_shift << 1;
						half_count <= '0;
						bit_count <= '0;
						state <= reader_shift;
					end else begin
						wait_count <= wait_count + 1'b1;
					end
				end
				reader_shift: begin
					if (!half_end) begin
						half_count <= half_count + 1'b1;
					end else begin
						half_count <= '0;
						sck <= !sck;
						// Falling edge
						if (sck) begin
							if (bit_count == sample_bits - 1) begin
								state <= reader_idle;
							end else begin
								bit_count <= bit_count + 1'b1;
								// Zeros follow once the word is out
								sdi <= config_shift[config_bits-1];
								config_shift <= config_shift << 1;
							end
						end
					end
				end
				default: state <= reader_idle;
			endcase
		end
	end

	// Result shift register and output sample
	always_ff @(posedge pll0_clock0) begin
		if (rise_tick) begin
			result_shift <= {result_shift[sample_bits-2:0], sdo};
		end
		if (result_ready) begin
			sample.channel <= converted_channel;
			sample.value <= result_shift;
		end
	end

endmodule

// ==== design/sample_text_framer.sv ====
// Sample to text line framer
`timescale 1ns/1ps

module sample_text_framer (
	input  logic                       pll0_clock0,
	input  logic                       master_reset_n,
	input  adc_uart_pkg::adc_sample_t  sample,
	input  logic                       sample_strobe,
	input  logic                       byte_done,
	output adc_uart_pkg::char_t        tx_byte,
	output logic                       byte_strobe
);
	import adc_uart_pkg::*;

	framer_state_t state;
	// Position within "chN=0xHHHH\r\n"
	logic [$clog2(message_bytes)-1:0] byte_index;
	adc_sample_t held_sample;
	// Result zero extended to four hex digits
	logic [15:0] hex_value;
	logic accept;

	// Upper case ASCII hex digit
	function automatic char_t hex_char(input logic [3:0] nibble);
		if (nibble < 4'd10) begin
			return 8'h30 + {4'h0, nibble};
		end
		// 'A' minus ten
		return 8'h37 + {4'h0, nibble};
	endfunction

	// Samples arriving mid line are dropped
	assign accept = (state == framer_idle) && sample_strobe;
	// One strobe per byte, the send state lasts a single cycle
	assign byte_strobe = (state == framer_send);
	assign hex_value = {{(16 - sample_bits){1'b0}}, held_sample.value};

	// ==================================================
	// Character select
	// ==================================================

	always_comb begin
		case (byte_index)
			4'd0: tx_byte = "c";
			4'd1: tx_byte = "h";
			// ASCII channel digit
			4'd2: tx_byte = 8'h30 + {5'b0, held_sample.channel};
			4'd3: tx_byte = "=";
			4'd4: tx_byte = "0";
			4'd5: tx_byte = "x";
			// Most significant nibble first
			4'd6: tx_byte = hex_char(hex_value[15:12]);
			4'd7: tx_byte = hex_char(hex_value[11:8]);
			4'd8: tx_byte = hex_char(hex_value[7:4]);
			4'd9: tx_byte = hex_char(hex_value[3:0]);
			// CR then LF
			4'd10: tx_byte = 8'h0d;
			4'd11: tx_byte = 8'h0a;
			default: tx_byte = 8'h00;
		endcase
	end

	// ==================================================
	// Line FSM
	// ==================================================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			state <= framer_idle;
			byte_index <= '0;
		end else begin
			case (state)
				framer_idle: begin
					if (sample_strobe) begin
						byte_index <= '0;
						state <= framer_send;
					end
				end
				// Byte handed to the serializer this cycle
				framer_send: state <= framer_wait_done;
				framer_wait_done: begin
					if (byte_done) begin
						if (byte_index == message_bytes - 1) begin
							// LF sent, line complete
							state <= framer_idle;
						end else begin
							byte_index <= byte_index + 1'b1;
							state <= framer_send;
						end
					end
				end
				default: state <= framer_idle;
			endcase
		end
	end

	// Sample held for the whole line
	always_ff @(posedge pll0_clock0) begin
		if (accept) begin
			held_sample <= sample;
		end
	end

endmodule

// ==== design/uart_tx_serializer.sv ====
// UART 8N1 transmitter
`timescale 1ns/1ps

module uart_tx_serializer (
	input  logic                 pll0_clock0,
	input  logic                 master_reset_n,
	input  adc_uart_pkg::char_t  tx_byte,
	input  logic                 byte_strobe,
	output logic                 tx,
	output logic                 byte_done
);
	import adc_uart_pkg::*;

	logic busy;
	logic [$clog2(baud_cycles)-1:0] baud_count;
	// 0 start, 1 to 8 data, 9 stop
	logic [3:0] bit_index;
	char_t data_shift;
	logic baud_end;
	logic load;

	assign baud_end = (baud_count == baud_cycles - 1);
	// Strobes while busy are ignored
	assign load = !busy && byte_strobe;
	// Last cycle of the stop bit
	assign byte_done = busy && baud_end && (bit_index == 4'd9);

	// ==================================================
	// Bit timing and line driver
	// ==================================================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			busy <= 1'b0;
			baud_count <= '0;
			bit_index <= '0;
			// Line idles high
			tx <= 1'b1;
		end else if (load) begin
			busy <= 1'b1;
			baud_count <= '0;
			bit_index <= '0;
			// Start bit
			tx <= 1'b0;
		end else if (busy) begin
			if (!baud_end) begin
				baud_count <= baud_count + 1'b1;
			end else begin
				baud_count <= '0;
				if (bit_index == 4'd9) begin
					busy <= 1'b0;
				end else begin
					bit_index <= bit_index + 1'b1;
					// Stop bit after the eighth data bit
					tx <= (bit_index == 4'd8) ? 1'b1 : data_shift[0];
				end
			end
		end
	end

	// Data bits, LSB first
	always_ff @(posedge pll0_clock0) begin
		if (load) begin
			data_shift <= tx_byte;
		end else if (busy && baud_end && (bit_index < 4'd8)) begin
			data_shift <= data_shift >> 1;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the streamer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	-f adc_uart_streamer.f \
	--top-module adc_uart_streamer_tb \
	-o adc_uart_streamer_sim || exit 1
result=$(./obj_dir/adc_uart_streamer_sim)
echo "$result"
echo "$result" | grep -qx "Test passed" && exit 0 || exit 1

// ==== verification/adc_uart_streamer_properties.sv ====
// Streamer pin assertions
`timescale 1ns/1ps

module adc_uart_streamer_properties (
	input logic pll0_clock0,
	input logic master_reset_n,
	input logic convst,
	input logic sck,
	input logic tx
);
	import adc_uart_pkg::*;

	// CONVST high time, counted on falling clock edges
	int high_count;

	always_ff @(negedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			high_count <= 0;
		end else if (convst) begin
			high_count <= high_count + 1;
		end else begin
			high_count <= 0;
		end
	end

	// No SCK activity during a conversion
	sck_quiet: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		convst |-> !sck)
		else $error("SCK high while CONVST is high");

	// Pulse width seen one edge after the fall
	convst_width: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		$fell(convst) |-> ($past(high_count) == conv_wait_cycles))
		else $error("CONVST pulse width differs from the conversion wait");

	tx_known: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		!$isunknown(tx))
		else $error("TX line unknown");

endmodule

bind adc_uart_streamer adc_uart_streamer_properties properties_0 (
	.pll0_clock0(pll0_clock0),
	.master_reset_n(master_reset_n),
	.convst(convst),
	.sck(sck),
	.tx(tx)
);

// ==== verification/adc_uart_streamer_tb.sv ====
// ADC to serial streamer testbench
`timescale 1ns/1ps

module adc_uart_streamer_tb;
	import adc_uart_pkg::*;

	logic pll0_clock0;
	logic master_reset_n;
	channel_t channel;
	logic sdo;
	logic convst;
	logic sck;
	logic sdi;
	logic tx;

	integer seed = 32'h2fd6_0e8f;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// ADC model state
	sample_t adc_value;
	channel_t model_channel = '0;
	logic [config_bits-1:0] config_word;
	logic [config_bits-1:0] last_config;
	int config_frames = 0;
	int model_bit;
	sample_t exp_values[$];
	channel_t exp_channels[$];

	// UART decoder state
	char_t rx_char;
	char_t rx_bytes[$];
	int rx_bit;
	int lines_received = 0;

	adc_uart_streamer uut (
		.pll0_clock0(pll0_clock0),
		.master_reset_n(master_reset_n),
		.channel(channel),
		.sdo(sdo),
		.convst(convst),
		.sck(sck),
		.sdi(sdi),
		.tx(tx)
	);

	initial begin
		pll0_clock0 = 1'b0;
		forever #2 pll0_clock0 = ~pll0_clock0;
	end

	// ==================================================
	// LTC2308 model
	// ==================================================

	// Value is fixed at CONVST rise, config word applies to the next one
	always @(posedge convst) begin
		adc_value = sample_t'($random(seed) & 32'h0000_0fff);
		exp_values.push_back(adc_value);
		exp_channels.push_back(model_channel);
		@(negedge convst);
		// MSB ready before the first SCK rise
		#1;
		sdo = adc_value[sample_bits-1];
		for (model_bit = 0; model_bit < sample_bits; model_bit++) begin
			@(posedge sck);
			if (model_bit < config_bits) begin
				config_word = {config_word[config_bits-2:0], sdi};
			end
			if (model_bit == config_bits - 1) begin
				last_config = config_word;
				config_frames++;
				// Channel is {S1, S0, OS}
				model_channel = {config_word[3], config_word[2], config_word[4]};
			end
			@(negedge sck);
			#1;
			if (model_bit < sample_bits - 1) begin
				sdo = adc_value[sample_bits-2-model_bit];
			end
		end
	end

	// ==================================================
	// UART decoder
	// ==================================================

	always @(negedge tx) begin
		if (master_reset_n === 1'b1) begin
			// Middle of the start bit
			repeat (baud_cycles / 2) @(negedge pll0_clock0);
			assert (tx === 1'b0) else begin
				$display("uart decoder: start bit did not stay low");
				error_count++;
			end
			for (rx_bit = 0; rx_bit < 8; rx_bit++) begin
				repeat (baud_cycles) @(negedge pll0_clock0);
				rx_char[rx_bit] = tx;
			end
			repeat (baud_cycles) @(negedge pll0_clock0);
			assert (tx === 1'b1) else begin
				$display("uart decoder: stop bit low after byte %0d", rx_bytes.size());
				error_count++;
			end
			rx_bytes.push_back(rx_char);
			if (rx_bytes.size() % message_bytes == 0) begin
				lines_received++;
			end
		end
	end

	// ==================================================
	// Helpers
	// ==================================================

	// Upper case hex digit by table lookup
	function automatic char_t hex_ascii(input logic [3:0] nibble);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[nibble];
	endfunction

	task automatic drive_channel(input channel_t ch);
		@(posedge pll0_clock0);
		#1;
		channel = ch;
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, error_count - start_errors);
		end
	endtask

	task automatic check_idle(input string name);
		assert (tx === 1'b1 && convst === 1'b0 && sck === 1'b0 && sdi === 1'b0) else begin
			$display("FAIL %s: expected tx,convst,sck,sdi = 1000 actual %b%b%b%b",
				name, tx, convst, sck, sdi);
			error_count++;
		end
	endtask

	// Counts falling clock edges up to the next CONVST rise
	task automatic wait_convst_rise(input string name, output int cycles);
		logic last;
		cycles = 0;
		last = convst;
		while (!(convst && !last) && cycles < sample_period_cycles + 100) begin
			last = convst;
			@(negedge pll0_clock0);
			cycles++;
		end
		assert (convst && !last) else begin
			$display("%s: timed out waiting for a CONVST rising edge", name);
			error_count++;
		end
	endtask

	task automatic wait_line(input string name, input int idx, output bit arrived);
		int waited;
		waited = 0;
		while (lines_received <= idx && waited < 3 * sample_period_cycles) begin
			@(negedge pll0_clock0);
			waited++;
		end
		arrived = (lines_received > idx);
		assert (arrived) else begin
			$display("%s: timed out waiting for text line %0d on tx", name, idx);
			error_count++;
		end
	endtask

	// Line idx must read "chN=0xHHHH" CR LF with the model's value
	task automatic check_line(input string name, input int idx, input channel_t ch);
		logic [8*message_bytes-1:0] expected;
		logic [8*message_bytes-1:0] actual;
		logic [15:0] value16;
		bit arrived;
		int k;
		wait_line(name, idx, arrived);
		if (arrived) begin
			// One conversion per line, none skipped
			assert (exp_values.size() == idx + 1) else begin
				$display("%s: line %0d arrived with %0d conversions recorded",
					name, idx, exp_values.size());
				error_count++;
			end
			assert (exp_channels[idx] == ch) else begin
				$display("FAIL %s: converted channel expected %0d actual %0d",
					name, ch, exp_channels[idx]);
				error_count++;
			end
			value16 = {4'h0, exp_values[idx]};
			expected = {"ch", char_t'(8'h30 + ch), "=0x",
				hex_ascii(value16[15:12]), hex_ascii(value16[11:8]),
				hex_ascii(value16[7:4]), hex_ascii(value16[3:0]), 8'h0d, 8'h0a};
			actual = '0;
			for (k = 0; k < message_bytes; k++) begin
				actual = {actual[8*message_bytes-9:0], rx_bytes[idx*message_bytes + k]};
			end
			assert (actual == expected) else begin
				$display("FAIL %s: line %0d expected %h actual %h",
					name, idx, expected, actual);
				error_count++;
			end
		end
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_reset_state();
		int start_errors;
		int cycles;
		start_errors = error_count;
		master_reset_n = 1'b0;
		repeat (3) begin
			@(posedge pll0_clock0);
			#1;
			check_idle("reset_state");
		end
		master_reset_n = 1'b1;
		cycles = 0;
		while (convst !== 1'b1 && cycles < sample_period_cycles + 100) begin
			check_idle("reset_state");
			@(posedge pll0_clock0);
			#1;
			cycles++;
		end
		assert (cycles == sample_period_cycles) else begin
			$display("FAIL reset_state: first CONVST rise expected %0d actual %0d",
				sample_period_cycles, cycles);
			error_count++;
		end
		report_test("reset_state", start_errors);
	endtask

	task automatic test_conversion_period();
		int start_errors;
		int gap;
		start_errors = error_count;
		// Align to a falling edge first
		wait_convst_rise("conversion_period", gap);
		repeat (2) begin
			wait_convst_rise("conversion_period", gap);
			assert (gap == sample_period_cycles) else begin
				$display("FAIL conversion_period: expected %0d actual %0d",
					sample_period_cycles, gap);
				error_count++;
			end
		end
		report_test("conversion_period", start_errors);
	endtask

	task automatic test_message_format();
		int start_errors;
		start_errors = error_count;
		// Channel has been 0 since reset
		check_line("message_format", exp_values.size() - 1, 3'd0);
		report_test("message_format", start_errors);
	endtask

	task automatic test_config_word(input channel_t ch);
		logic [config_bits-1:0] expected_word;
		string name;
		int start_errors;
		int cycles;
		int frames;
		start_errors = error_count;
		name = $sformatf("config_word_ch%0d", ch);
		drive_channel(ch);
		wait_convst_rise(name, cycles);
		frames = config_frames;
		cycles = 0;
		while (config_frames == frames && cycles < 4 * conv_wait_cycles) begin
			@(negedge pll0_clock0);
			cycles++;
		end
		assert (config_frames != frames) else begin
			$display("%s: no configuration word seen on SDI", name);
			error_count++;
		end
		// SD, OS, S1, S0, UNI, SLP
		expected_word = {1'b1, ch[0], ch[2], ch[1], 1'b1, 1'b0};
		assert (last_config == expected_word) else begin
			$display("FAIL %s: expected %b actual %b", name, expected_word, last_config);
			error_count++;
		end
		report_test(name, start_errors);
	endtask

	task automatic test_channel_lag(input channel_t new_ch);
		channel_t old_ch;
		int start_errors;
		int idx;
		bit arrived;
		start_errors = error_count;
		old_ch = channel;
		idx = exp_values.size() - 1;
		wait_line("channel_lag", idx, arrived);
		drive_channel(new_ch);
		// Old channel is still configured for the next conversion
		check_line("channel_lag", idx + 1, old_ch);
		check_line("channel_lag", idx + 2, new_ch);
		report_test("channel_lag", start_errors);
	endtask

	task automatic test_random_sequence();
		channel_t running;
		channel_t next_ch;
		int start_errors;
		int i;
		int idx;
		start_errors = error_count;
		// Sampled by the last CONVST rise
		running = channel;
		for (i = 0; i < 5; i++) begin
			idx = exp_values.size();
			next_ch = channel_t'($random(seed) & 7);
			drive_channel(next_ch);
			check_line("random_sequence", idx, running);
			running = next_ch;
		end
		report_test("random_sequence", start_errors);
	endtask

	initial begin
		master_reset_n = 1'b0;
		channel = '0;
		sdo = 1'b0;
		test_reset_state();
		test_conversion_period();
		test_message_format();
		test_config_word(3'd5);
		test_config_word(3'd3);
		test_config_word(3'd6);
		test_channel_lag(3'd1);
		test_random_sequence();
		$display("Summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
